// ==== build.f ====
hdl/cache_geometry_pkg.sv
hdl/riscv_lsu_pkg.sv
hdl/data_bank.sv
hdl/data_block.sv
hdl/fill_store_unit.sv
hdl/load_unit.sv
hdl/dcache_data_top.sv
testbench/tb_dcache_data.sv

// ==== hdl/cache_geometry_pkg.sv ====
/*
 * Geometry of the data cache data array. The localparams and address-field
 * types here are shared by the fill/store unit, the banks and the load unit.
 * Modules refer to them by scoped name.
 */

package cache_geometry_pkg;

    // Byte address width seen by the load/store path
    localparam int ADDR_WIDTH = 32;

    // Width of one data word, which is also the width of one bank
    localparam int WORD_WIDTH = 32;

    // Bank select bits, one bank per word of the line
    localparam int BANK_ADDRESS = 2;
    localparam int BANK_NUMBER = 2 ** BANK_ADDRESS;

    // Byte within word, then bank, then set index
    localparam int OFFSET_BITS = 2;
    localparam int SET_BITS = 6;

    // Position of the bank and set fields inside a byte address
    localparam int BANK_LSB = OFFSET_BITS;
    localparam int SET_LSB = OFFSET_BITS + BANK_ADDRESS;

    typedef logic [ADDR_WIDTH - 1:0] addr_t;
    typedef logic [BANK_ADDRESS - 1:0] bank_idx_t;
    typedef logic [SET_BITS - 1:0] set_idx_t;
    typedef logic [OFFSET_BITS - 1:0] byte_off_t;
    typedef logic [WORD_WIDTH - 1:0] data_word_t;

endpackage : cache_geometry_pkg

// ==== hdl/data_bank.sv ====
/*
 * One bank of the data array: one 32-bit word per set, byte write enables
 * and a registered read port. Reads are read-first, so a read and a write to
 * the same set at the same edge return the previous contents.
 */

`timescale 1ns/10ps

module data_bank (
    input  logic                            clk_i,

    // Write port
    input  logic                            write_i,
    input  cache_geometry_pkg::set_idx_t    write_set_i,
    input  riscv_lsu_pkg::byte_mask_t       byte_write_i,
    input  cache_geometry_pkg::data_word_t  write_data_i,

    // Read port
    input  logic                            read_i,
    input  cache_geometry_pkg::set_idx_t    read_set_i,
    output cache_geometry_pkg::data_word_t  read_data_o
);

    localparam int DEPTH = 2 ** cache_geometry_pkg::SET_BITS;

    // Storage array, one word per set
    cache_geometry_pkg::data_word_t mem [DEPTH];

    // --------------------
    // Write port
    // --------------------

    // Only the enabled byte lanes are updated, the rest keep their value
    always_ff @(posedge clk_i) begin
        if (write_i) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_write_i[b]) begin
                    mem[write_set_i][8 * b +: 8] <= write_data_i[8 * b +: 8];
                end
            end
        end
    end

    // --------------------
    // Read port
    // --------------------

    // The non-blocking read samples the array before any write at this edge
    // lands, which gives read-first behavior
    always_ff @(posedge clk_i) begin
        if (read_i) begin
            read_data_o <= mem[read_set_i];
        end
    end

endmodule : data_bank

// ==== hdl/data_block.sv ====
/*
 * Banked data array of the cache. One word-wide bank per word of the line;
 * the bank index selects which bank is enabled for a write or a read, and
 * the read bank is held for a cycle to pick the bank output that returns.
 */

`timescale 1ns/10ps

module data_block #(
    // Number of bank select bits, 4 banks by default
    parameter int BANK_ADDRESS = cache_geometry_pkg::BANK_ADDRESS
) (
    input  logic                            clk_i,

    // Write port
    input  logic [BANK_ADDRESS - 1:0]       write_bank_i,
    input  cache_geometry_pkg::set_idx_t    write_set_i,
    input  riscv_lsu_pkg::byte_mask_t       byte_write_i,
    input  logic                            write_i,
    input  cache_geometry_pkg::data_word_t  write_data_i,

    // Read port
    input  logic [BANK_ADDRESS - 1:0]       read_bank_i,
    input  cache_geometry_pkg::set_idx_t    read_set_i,
    input  logic                            read_i,
    output cache_geometry_pkg::data_word_t  read_data_o
);

    localparam int BANK_NUMBER = 2 ** BANK_ADDRESS;

    // --------------------
    // Bank decode
    // --------------------

    // One-hot enables, so exactly one bank sees each access
    logic [BANK_NUMBER - 1:0] write_enable;
    logic [BANK_NUMBER - 1:0] read_enable;

    assign write_enable = BANK_NUMBER'(1) << write_bank_i;
    assign read_enable = BANK_NUMBER'(1) << read_bank_i;

    // --------------------
    // Banks
    // --------------------

    // Registered output of every bank
    cache_geometry_pkg::data_word_t read_data [BANK_NUMBER];

    for (genvar i = 0; i < BANK_NUMBER; i++) begin : g_bank
        data_bank bank_i (
            .clk_i        (clk_i),
            .write_i      (write_i & write_enable[i]),
            .write_set_i  (write_set_i),
            .byte_write_i (byte_write_i),
            .write_data_i (write_data_i),
            .read_i       (read_i & read_enable[i]),
            .read_set_i   (read_set_i),
            .read_data_o  (read_data[i])
        );
    end

    // --------------------
    // Output select
    // --------------------

    // Bank data arrives one cycle after the read, so remember which bank was read
    logic [BANK_ADDRESS - 1:0] data_select;

    // Held between reads so the output stays stable while idle
    always_ff @(posedge clk_i) begin
        if (read_i) begin
            data_select <= read_bank_i;
        end
    end

    assign read_data_o = read_data[data_select];

endmodule : data_block

// ==== hdl/dcache_data_top.sv ====
/*
 * Data array of the data cache with its writer and reader. The fill/store
 * unit drives the write port, the load unit drives the read port.
 */

`timescale 1ns/10ps

module dcache_data_top (
    input  logic                            clk_i,
    input  logic                            reset_i,

    // Line refill
    input  logic                            fill_start_i,
    input  cache_geometry_pkg::set_idx_t    fill_set_i,
    input  logic                            fill_word_i,
    input  cache_geometry_pkg::data_word_t  fill_data_i,
    output logic                            fill_busy_o,
    output logic                            fill_done_o,

    // CPU store
    input  logic                            store_i,
    input  cache_geometry_pkg::addr_t       store_addr_i,
    input  riscv_lsu_pkg::ls_width_t        store_width_i,
    input  cache_geometry_pkg::data_word_t  store_data_i,

    // CPU load
    input  logic                            load_i,
    input  cache_geometry_pkg::addr_t       load_addr_i,
    input  riscv_lsu_pkg::ls_width_t        load_width_i,
    output logic                            load_valid_o,
    output cache_geometry_pkg::data_word_t  load_data_o
);

    // Write path from the fill/store unit
    logic wr_en;
    cache_geometry_pkg::bank_idx_t wr_bank;
    cache_geometry_pkg::set_idx_t wr_set;
    riscv_lsu_pkg::byte_mask_t wr_mask;
    cache_geometry_pkg::data_word_t wr_data;

    // Read path to and from the load unit
    logic rd_en;
    cache_geometry_pkg::bank_idx_t rd_bank;
    cache_geometry_pkg::set_idx_t rd_set;
    cache_geometry_pkg::data_word_t rd_data;

    fill_store_unit fill_store_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .fill_start_i  (fill_start_i),
        .fill_set_i    (fill_set_i),
        .fill_word_i   (fill_word_i),
        .fill_data_i   (fill_data_i),
        .store_i       (store_i),
        .store_addr_i  (store_addr_i),
        .store_width_i (store_width_i),
        .store_data_i  (store_data_i),
        .fill_busy_o   (fill_busy_o),
        .fill_done_o   (fill_done_o),
        .wr_en_o       (wr_en),
        .wr_bank_o     (wr_bank),
        .wr_set_o      (wr_set),
        .wr_mask_o     (wr_mask),
        .wr_data_o     (wr_data)
    );

    data_block data_block_i (
        .clk_i        (clk_i),
        .write_bank_i (wr_bank),
        .write_set_i  (wr_set),
        .byte_write_i (wr_mask),
        .write_i      (wr_en),
        .write_data_i (wr_data),
        .read_bank_i  (rd_bank),
        .read_set_i   (rd_set),
        .read_i       (rd_en),
        .read_data_o  (rd_data)
    );

    load_unit load_i_unit (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .load_i       (load_i),
        .load_addr_i  (load_addr_i),
        .load_width_i (load_width_i),
        .rd_en_o      (rd_en),
        .rd_bank_o    (rd_bank),
        .rd_set_o     (rd_set),
        .rd_data_i    (rd_data),
        .load_valid_o (load_valid_o),
        .load_data_o  (load_data_o)
    );

endmodule : dcache_data_top

// ==== hdl/fill_store_unit.sv ====
/*
 * Writer side of the data array. Refills a whole line from the memory return
 * stream, one word per strobe in bank order, and merges CPU byte, halfword
 * and word stores into the addressed bank. All write outputs are registered.
 */

`timescale 1ns/10ps

module fill_store_unit (
    input  logic                            clk_i,
    input  logic                            reset_i,

    // Line refill stream
    input  logic                            fill_start_i,
    input  cache_geometry_pkg::set_idx_t    fill_set_i,
    input  logic                            fill_word_i,
    input  cache_geometry_pkg::data_word_t  fill_data_i,

    // CPU store
    input  logic                            store_i,
    input  cache_geometry_pkg::addr_t       store_addr_i,
    input  riscv_lsu_pkg::ls_width_t        store_width_i,
    input  cache_geometry_pkg::data_word_t  store_data_i,

    // Refill status
    output logic                            fill_busy_o,
    output logic                            fill_done_o,

    // Write port towards the data array
    output logic                            wr_en_o,
    output cache_geometry_pkg::bank_idx_t   wr_bank_o,
    output cache_geometry_pkg::set_idx_t    wr_set_o,
    output riscv_lsu_pkg::byte_mask_t       wr_mask_o,
    output cache_geometry_pkg::data_word_t  wr_data_o
);

    typedef enum logic [0:0] {
        IDLE,
        FILL
    } fill_state_t;

    fill_state_t state_q;

    // Set being refilled and the bank that takes the next fill word
    cache_geometry_pkg::set_idx_t fill_set_q;
    cache_geometry_pkg::bank_idx_t fill_bank_q;

    logic fill_accept;
    logic last_word;

    // A fill word only counts while a refill is running
    assign fill_accept = (state_q == FILL) && fill_word_i;
    assign last_word = fill_bank_q == cache_geometry_pkg::bank_idx_t'(
        cache_geometry_pkg::BANK_NUMBER - 1);

    assign fill_busy_o = (state_q == FILL);

    // --------------------
    // Refill FSM
    // --------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
            fill_bank_q <= '0;
            fill_done_o <= 1'b0;
        end else begin
            fill_done_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (fill_start_i) begin
                        state_q <= FILL;
                        fill_bank_q <= '0;
                    end
                end
                FILL: begin
                    if (fill_word_i) begin
                        fill_bank_q <= fill_bank_q + 1'b1;
                        // The last bank closes the refill
                        if (last_word) begin
                            state_q <= IDLE;
                            fill_done_o <= 1'b1;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // The refill set is captured once per line
    always_ff @(posedge clk_i) begin
        if (fill_start_i && (state_q == IDLE)) begin
            fill_set_q <= fill_set_i;
        end
    end

    // --------------------
    // Store merge
    // --------------------

    cache_geometry_pkg::byte_off_t store_off;
    riscv_lsu_pkg::byte_mask_t store_mask;
    cache_geometry_pkg::data_word_t store_lanes;

    assign store_off = store_addr_i[cache_geometry_pkg::OFFSET_BITS - 1:0];

    // Narrow data is copied onto every lane, the mask then picks the right one
    always_comb begin
        case (store_width_i)
            riscv_lsu_pkg::LS_BYTE: begin
                store_lanes = {4{store_data_i[7:0]}};
                store_mask = 4'b0001 << store_off;
            end
            riscv_lsu_pkg::LS_HALF: begin
                store_lanes = {2{store_data_i[15:0]}};
                store_mask = 4'b0011 << store_off;
            end
            default: begin
                store_lanes = store_data_i;
                store_mask = 4'b1111;
            end
        endcase
    end

    // --------------------
    // Write outputs
    // --------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= store_i || fill_accept;
        end
    end

    // Stores and fill words never overlap, since stores are illegal while busy
    always_ff @(posedge clk_i) begin
        if (fill_accept) begin
            wr_bank_o <= fill_bank_q;
            wr_set_o <= fill_set_q;
            wr_mask_o <= 4'b1111;
            wr_data_o <= fill_data_i;
        end else if (store_i) begin
            wr_bank_o <= store_addr_i[cache_geometry_pkg::BANK_LSB
                                      +: cache_geometry_pkg::BANK_ADDRESS];
            wr_set_o <= store_addr_i[cache_geometry_pkg::SET_LSB +: cache_geometry_pkg::SET_BITS];
            wr_mask_o <= store_mask;
            wr_data_o <= store_lanes;
        end
    end

    // --------------------
    // Environment rules
    // --------------------

    // A refill owns the write port until its done pulse
    a_no_start_when_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        fill_busy_o |-> !(store_i || fill_start_i))
        else $error("store or fill start while a refill is running");

    a_no_word_when_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == IDLE) |-> !fill_word_i)
        else $error("fill word with no refill running");

    // Misaligned stores are not supported
    a_half_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        (store_i && store_width_i == riscv_lsu_pkg::LS_HALF) |-> !store_off[0])
        else $error("misaligned halfword store");

    a_word_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        (store_i && store_width_i == riscv_lsu_pkg::LS_WORD) |-> (store_off == '0))
        else $error("misaligned word store");

endmodule : fill_store_unit

// ==== hdl/load_unit.sv ====
/*
 * Reader side of the data array. Issues the bank read in the cycle of the
 * load request and, one cycle later, aligns the returned word and sign- or
 * zero-extends the byte, halfword or word.
 */

`timescale 1ns/10ps

module load_unit (
    input  logic                            clk_i,
    input  logic                            reset_i,

    // Load request
    input  logic                            load_i,
    input  cache_geometry_pkg::addr_t       load_addr_i,
    input  riscv_lsu_pkg::ls_width_t        load_width_i,

    // Read port towards the data array
    output logic                            rd_en_o,
    output cache_geometry_pkg::bank_idx_t   rd_bank_o,
    output cache_geometry_pkg::set_idx_t    rd_set_o,
    input  cache_geometry_pkg::data_word_t  rd_data_i,

    // Load result
    output logic                            load_valid_o,
    output cache_geometry_pkg::data_word_t  load_data_o
);

    // --------------------
    // Request stage
    // --------------------

    cache_geometry_pkg::byte_off_t load_off;

    // The array read goes out in the same cycle as the request
    assign rd_en_o = load_i;
    assign rd_bank_o = load_addr_i[cache_geometry_pkg::BANK_LSB
                                   +: cache_geometry_pkg::BANK_ADDRESS];
    assign rd_set_o = load_addr_i[cache_geometry_pkg::SET_LSB +: cache_geometry_pkg::SET_BITS];
    assign load_off = load_addr_i[cache_geometry_pkg::OFFSET_BITS - 1:0];

    cache_geometry_pkg::byte_off_t off_q;
    riscv_lsu_pkg::ls_width_t width_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            load_valid_o <= 1'b0;
        end else begin
            load_valid_o <= load_i;
        end
    end

    // Offset and width travel alongside the read
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            off_q <= load_off;
            width_q <= load_width_i;
        end
    end

    // --------------------
    // Return stage
    // --------------------

    cache_geometry_pkg::data_word_t shifted;
    logic sign_en;

    always_comb begin
        // Move the addressed lane down to bit 0
        shifted = rd_data_i >> {off_q, 3'b000};
        sign_en = !width_q[riscv_lsu_pkg::UNSIGNED_BIT];
        case (width_q)
            riscv_lsu_pkg::LS_BYTE, riscv_lsu_pkg::LS_BYTE_U: begin
                load_data_o = {{24{sign_en & shifted[7]}}, shifted[7:0]};
            end
            riscv_lsu_pkg::LS_HALF, riscv_lsu_pkg::LS_HALF_U: begin
                load_data_o = {{16{sign_en & shifted[15]}}, shifted[15:0]};
            end
            default: load_data_o = shifted;
        endcase
    end

    // Halfwords on even bytes, words on word boundaries
    a_load_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        load_i |-> (load_width_i[1:0] == 2'd0)
                || (load_width_i[1:0] == 2'd1 && !load_off[0])
                || (load_width_i[1:0] == 2'd2 && load_off == '0))
        else $error("misaligned load");

endmodule : load_unit

// ==== hdl/riscv_lsu_pkg.sv ====
/*
 * Load/store width codes, in the RISC-V funct3 encoding, and the
 * byte-lane write mask used by stores into the data array.
 */

package riscv_lsu_pkg;

    typedef logic [2:0] ls_width_t;

    // Signed and word accesses
    localparam ls_width_t LS_BYTE = 3'd0;
    localparam ls_width_t LS_HALF = 3'd1;
    localparam ls_width_t LS_WORD = 3'd2;

    // Zero-extending loads
    localparam ls_width_t LS_BYTE_U = 3'd4;
    localparam ls_width_t LS_HALF_U = 3'd5;

    // This bit of the width code selects zero extension on loads
    localparam int UNSIGNED_BIT = 2;

    // One enable per byte lane, lane 0 is the least significant byte
    typedef logic [3:0] byte_mask_t;

endpackage : riscv_lsu_pkg

// ==== run_sim.sh ====
#!/bin/sh
# Builds the data cache data array testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the test fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
    --top-module tb_dcache_data -f build.f -o tb_dcache_data
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_dcache_data
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0

// ==== testbench/dcache_stim.mem ====
// Columns: op, byte address, width code, data, expected load value
// Ops: 0 idle, 1 fill start (address gives the set), 2 fill word, 3 store, 4 load, f end
// Refill of set 5 with a gap between the 2nd and 3rd word
1 00000050 0 00000000 00000000
2 00000000 0 A1B2C3D4 00000000
2 00000000 0 8899AABB 00000000
0 00000000 0 00000000 00000000
2 00000000 0 11223344 00000000
2 00000000 0 F0E1D2C3 00000000
0 00000000 0 00000000 00000000
// Back-to-back word loads of the four banks of set 5
4 00000050 2 00000000 A1B2C3D4
4 00000054 2 00000000 8899AABB
4 00000058 2 00000000 11223344
4 0000005C 2 00000000 F0E1D2C3
// Byte and halfword merges, upper data bits must not leak into the word
3 00000051 0 AABBCCEE 00000000
3 0000005A 1 99887788 00000000
0 00000000 0 00000000 00000000
4 00000050 2 00000000 A1B2EED4
4 00000058 2 00000000 77883344
// Sign and zero extension, every lane has its top bit set
3 00000100 2 8192A3B4 00000000
0 00000000 0 00000000 00000000
4 00000100 0 00000000 FFFFFFB4
4 00000101 0 00000000 FFFFFFA3
4 00000102 0 00000000 FFFFFF92
4 00000103 0 00000000 FFFFFF81
4 00000100 4 00000000 000000B4
4 00000101 4 00000000 000000A3
4 00000102 4 00000000 00000092
4 00000103 4 00000000 00000081
4 00000100 1 00000000 FFFFA3B4
4 00000102 1 00000000 FFFF8192
4 00000100 5 00000000 0000A3B4
4 00000102 5 00000000 00008192
// Same set in two banks, and the same bank in another set
3 00000204 2 00000000 13579BDF
3 00000208 2 2468ACE0 00000000
3 00000304 2 0F1E2D3C 00000000
0 00000000 0 00000000 00000000
4 00000204 2 00000000 00000000
4 00000208 2 00000000 2468ACE0
4 00000304 2 00000000 0F1E2D3C
4 00000100 2 00000000 8192A3B4
4 00000054 2 00000000 8899AABB
F 00000000 0 00000000 00000000

// ==== testbench/tb_dcache_data.sv ====
/*
 * Testbench for the data cache data array. Replays the stim file one record
 * per clock into the top level and checks every load result against the
 * expected value of its record, plus the refill busy and done timing.
 */

`timescale 1ns/10ps

module tb_dcache_data;

    // Each record in the stim file takes five words
    localparam int FIELDS = 5;
    localparam int MAX_RECORDS = 128;

    // Record operation codes
    localparam int OP_FILL_START = 1;
    localparam int OP_FILL_WORD = 2;
    localparam int OP_STORE = 3;
    localparam int OP_LOAD = 4;
    localparam int OP_END = 15;

    // Clock starts low without a time-zero edge
    logic clk_i = 1'b0;
    logic reset_i;

    logic fill_start_i;
    cache_geometry_pkg::set_idx_t fill_set_i;
    logic fill_word_i;
    cache_geometry_pkg::data_word_t fill_data_i;
    logic fill_busy_o;
    logic fill_done_o;
    logic store_i;
    cache_geometry_pkg::addr_t store_addr_i;
    riscv_lsu_pkg::ls_width_t store_width_i;
    cache_geometry_pkg::data_word_t store_data_i;
    logic load_i;
    cache_geometry_pkg::addr_t load_addr_i;
    riscv_lsu_pkg::ls_width_t load_width_i;
    logic load_valid_o;
    cache_geometry_pkg::data_word_t load_data_o;

    cache_geometry_pkg::data_word_t stim [FIELDS * MAX_RECORDS];

    // Expected results of loads in flight, oldest first
    cache_geometry_pkg::data_word_t expect_q [$];

    int num_records;
    int cycle_limit = 50;
    int cycles = 0;

    // Expected refill status, one cycle behind the strobes
    logic busy_exp;
    logic done_exp;
    int fill_count;

    // Expected load result strobe, one cycle behind the load
    logic valid_exp;

    dcache_data_top dut_i (.*);

    always #5 clk_i = ~clk_i;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic stop_run(input string reason);
        $display("Failure at %0t: %s", $time, reason);
        $display("TEST FAILED");
        $fatal(1, "Run stopped");
    endtask

    // Drives one record onto the DUT inputs, only its own strobe goes high
    task automatic apply_record(input int idx);
        int op;
        cache_geometry_pkg::addr_t addr;
        riscv_lsu_pkg::ls_width_t width;
        cache_geometry_pkg::data_word_t data;
        op = int'(stim[FIELDS * idx]);
        addr = stim[FIELDS * idx + 1];
        width = stim[FIELDS * idx + 2][2:0];
        data = stim[FIELDS * idx + 3];
        fill_start_i <= (op == OP_FILL_START);
        fill_set_i <= addr[cache_geometry_pkg::SET_LSB +: cache_geometry_pkg::SET_BITS];
        fill_word_i <= (op == OP_FILL_WORD);
        fill_data_i <= data;
        store_i <= (op == OP_STORE);
        store_addr_i <= addr;
        store_width_i <= width;
        store_data_i <= data;
        load_i <= (op == OP_LOAD);
        load_addr_i <= addr;
        load_width_i <= width;
        if (op == OP_LOAD) begin
            expect_q.push_back(stim[FIELDS * idx + 4]);
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------

    initial begin
        reset_i = 1'b1;
        fill_start_i = 1'b0;
        fill_set_i = '0;
        fill_word_i = 1'b0;
        fill_data_i = '0;
        store_i = 1'b0;
        store_addr_i = '0;
        store_width_i = '0;
        store_data_i = '0;
        load_i = 1'b0;
        load_addr_i = '0;
        load_width_i = '0;
        $readmemh("testbench/dcache_stim.mem", stim);
        num_records = 0;
        while (num_records < MAX_RECORDS && stim[FIELDS * num_records] != OP_END) begin
            num_records++;
        end
        if (num_records == MAX_RECORDS) begin
            stop_run("the stim file has no end record");
        end
        cycle_limit = 2 * num_records + 50;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        for (int i = 0; i < num_records; i++) begin
            @(posedge clk_i);
            apply_record(i);
        end
        // The end record drives every strobe low
        @(posedge clk_i);
        apply_record(num_records);
        // Load latency is one cycle, so two more edges drain the pipeline
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        if (expect_q.size() != 0) begin
            stop_run("some loads never returned a result");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

    // --------------------
    // Refill status model
    // --------------------

    // Busy rises the cycle after the start and falls with done after the 4th word
    always @(posedge clk_i) begin
        if (reset_i) begin
            busy_exp <= 1'b0;
            done_exp <= 1'b0;
            fill_count <= 0;
        end else begin
            done_exp <= 1'b0;
            if (fill_start_i) begin
                busy_exp <= 1'b1;
                fill_count <= 0;
            end else if (fill_word_i) begin
                fill_count <= fill_count + 1;
                if (fill_count == cache_geometry_pkg::BANK_NUMBER - 1) begin
                    busy_exp <= 1'b0;
                    done_exp <= 1'b1;
                end
            end
        end
    end

    // A load returns its result exactly one cycle after it is issued
    always @(posedge clk_i) begin
        if (reset_i) begin
            valid_exp <= 1'b0;
        end else begin
            valid_exp <= load_i;
        end
    end

    // --------------------
    // Output checks
    // --------------------

    // Outputs are sampled mid-cycle, well clear of the clock edge
    always @(negedge clk_i) begin
        check_value(32'(load_valid_o), 32'(valid_exp), "load_valid_o");
        check_value(32'(fill_busy_o), 32'(busy_exp), "fill_busy_o");
        if (done_exp && !fill_done_o) begin
            stop_run("fill_done_o did not pulse one cycle after the last fill word");
        end else begin
            check_value(32'(fill_done_o), 32'(done_exp), "fill_done_o");
        end
        if (load_valid_o) begin
            if (expect_q.size() == 0) begin
                stop_run("load_valid_o came with no load outstanding");
            end else begin
                check_value(load_data_o, expect_q.pop_front(), "load_data_o");
            end
        end
    end

    // Guards against a hung run
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            stop_run($sformatf("the run passed its limit of %0d cycles", cycle_limit));
        end
    end

endmodule : tb_dcache_data
